/* sources.f */
common_pkg.sv
wb_bus_if.sv
address_decoding.sv
wb_interconnect.sv
keyboard.sv
sys_ctrl.sv
pet_io_top.sv
tb_pet_io.sv

/* tb_pet_io.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_pet_io;

    localparam int CLK_HALF     = 4;                        // 8 ns period
    localparam int RESET_CYCLES = 16;
    localparam int COLS         = common_pkg::KBD_COL_COUNT;
    localparam int DW           = common_pkg::DATA_WIDTH;
    localparam int AW           = common_pkg::WB_ADDR_WIDTH;
    localparam int CAW          = common_pkg::CPU_ADDR_WIDTH;
    localparam int NUM_OPS      = 6 * COLS + 20;            // Bound on bus operations issued
    localparam int OP_CYCLES    = 10;
    localparam logic [CAW-1:0] PIA1 = common_pkg::PIA1_BASE;

    logic           wb_clock_i;
    logic           rst_n_i;
    logic [AW-1:0]  wb_addr_i;
    logic [DW-1:0]  wb_data_i;
    logic           wb_we_i;
    logic           wb_cycle_i;
    logic           wb_strobe_i;
    logic [DW-1:0]  wb_data_o;
    logic           wb_ack_o;
    logic           wb_stall_o;
    logic [CAW-1:0] cpu_addr_i;
    logic           cpu_be_i;
    logic           cpu_we_i;
    logic           cpu_data_strobe_i;
    logic [DW-1:0]  cpu_data_i;
    logic [DW-1:0]  cpu_data_o;
    logic           cpu_data_oe_o;
    logic           cpu_reset_o;
    logic           gfx_o;

    // Reference model of both matrices and the column latch
    logic [DW-1:0]  usb_model [COLS];
    logic [DW-1:0]  pet_model [COLS];
    logic [3:0]     sel_model;
    logic           exp_reset;
    logic           exp_gfx;
    logic           exp_oe;           // Intercept expected after the current CPU read
    logic [DW-1:0]  exp_cpu_data;
    logic [DW-1:0]  exp_wb_data;      // Read data expected with the next ack
    integer         seed;

    pet_io_top #(.KBD_COLS(COLS), .PIA1_ADDR(PIA1)) dut (.*);

    always #CLK_HALF wb_clock_i = ~wb_clock_i;

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [DW-1:0] expected,
                                   input logic [DW-1:0] actual);
        $display("FAILED at %0t ns: %s expected %h, actual %h", $time, name, expected, actual);
        abort_run();
    endtask

    function automatic logic in_pia1(input logic [CAW-1:0] addr);
        return addr[CAW-1:4] == PIA1[CAW-1:4];   // 16 byte window
    endfunction

    function automatic logic is_port_b(input logic [CAW-1:0] addr);
        return in_pia1(addr) && (addr[1:0] == common_pkg::PIA_PORTB);
    endfunction

    // What an MCU read of this address should return
    function automatic logic [DW-1:0] expected_read(input logic [AW-1:0] addr);
        logic [DW-1:0] value;
        value = '0;                                  // Holes in the map read zero
        if (addr[7:5] == 3'd0 && addr[4] == common_pkg::WB_SYS_PAGE) begin
            if (addr[3:0] == common_pkg::SYS_REG_RESET)
                value = {{(DW-1){1'b0}}, exp_reset};
            else if (addr[3:0] == common_pkg::SYS_REG_GFX)
                value = {{(DW-1){1'b0}}, exp_gfx};
        end else if (addr[7:5] == 3'd0 && addr[3:0] < COLS) begin
            value = pet_model[addr[3:0]];            // Keyboard page returns PET column
        end
        return value;
    endfunction

    task automatic start_cycle(input logic [AW-1:0] addr, input logic [DW-1:0] data,
                               input logic we);
        @(posedge wb_clock_i);
        wb_addr_i   <= addr;
        wb_data_i   <= data;
        wb_we_i     <= we;
        wb_cycle_i  <= 1'b1;
        wb_strobe_i <= 1'b1;
    endtask

    // Strobe lasts one clock before the wait for the ack
    task automatic finish_cycle();
        int   waited;
        logic got_ack;
        @(posedge wb_clock_i);
        wb_strobe_i <= 1'b0;
        wb_cycle_i  <= 1'b0;
        wb_we_i     <= 1'b0;
        waited  = 0;
        got_ack = 1'b0;
        while (!got_ack && waited < 4) begin
            @(negedge wb_clock_i);
            got_ack = wb_ack_o;
            waited++;
        end
        if (!got_ack) begin
            $display("Error: no Wishbone ack for address %h", wb_addr_i);
            abort_run();
        end
    endtask

    task automatic mcu_write(input logic [AW-1:0] addr, input logic [DW-1:0] data);
        start_cycle(addr, data, 1'b1);
        if (addr[7:5] == 3'd0 && addr[4] == common_pkg::WB_KBD_PAGE && addr[3:0] < COLS)
            usb_model[addr[3:0]] = data;
        finish_cycle();
        if (addr[7:5] == 3'd0 && addr[4] == common_pkg::WB_SYS_PAGE) begin
            if (addr[3:0] == common_pkg::SYS_REG_RESET)
                exp_reset <= data[0];
            else if (addr[3:0] == common_pkg::SYS_REG_GFX)
                exp_gfx <= data[0];
        end
    endtask

    task automatic mcu_read(input logic [AW-1:0] addr);
        start_cycle(addr, '0, 1'b0);
        exp_wb_data <= expected_read(addr);
        finish_cycle();
    endtask

    // One strobed CPU cycle followed by two idle clocks for the row register
    task automatic cpu_write(input logic [CAW-1:0] addr, input logic [DW-1:0] data);
        @(posedge wb_clock_i);
        cpu_addr_i        <= addr;
        cpu_be_i          <= 1'b1;
        cpu_we_i          <= 1'b1;
        cpu_data_strobe_i <= 1'b1;
        cpu_data_i        <= data;
        if (in_pia1(addr) && addr[1:0] == common_pkg::PIA_PORTA)
            sel_model = data[common_pkg::PIA1_PORTA_KEY_D_OUT:
                             common_pkg::PIA1_PORTA_KEY_A_OUT];
        @(posedge wb_clock_i);
        cpu_be_i          <= 1'b0;
        cpu_we_i          <= 1'b0;
        cpu_data_strobe_i <= 1'b0;
        repeat (2) @(posedge wb_clock_i);
    endtask

    task automatic cpu_read(input logic [CAW-1:0] addr, input logic [DW-1:0] data);
        logic [DW-1:0] row;
        row = (sel_model < COLS) ? usb_model[sel_model] : '1;
        @(posedge wb_clock_i);
        cpu_addr_i        <= addr;
        cpu_be_i          <= 1'b1;
        cpu_we_i          <= 1'b0;
        cpu_data_strobe_i <= 1'b1;
        cpu_data_i        <= data;                      // Real matrix value on the bus
        exp_oe            <= is_port_b(addr) && (row != '1);
        exp_cpu_data      <= row;
        if (is_port_b(addr) && sel_model < COLS)
            pet_model[sel_model] = data;
        @(posedge wb_clock_i);
        cpu_be_i          <= 1'b0;
        cpu_data_strobe_i <= 1'b0;
        repeat (2) @(posedge wb_clock_i);
    endtask

    wb_ack_follows: assert property (@(posedge wb_clock_i) disable iff (!rst_n_i)
        (wb_cycle_i && wb_strobe_i) |=> wb_ack_o)
        else report_mismatch("wb_ack_o", 8'd1, DW'($sampled(wb_ack_o)));
    wb_ack_spurious: assert property (@(posedge wb_clock_i) disable iff (!rst_n_i)
        wb_ack_o |-> $past(wb_cycle_i && wb_strobe_i))
        else report_mismatch("wb_ack_o", 8'd0, DW'($sampled(wb_ack_o)));
    wb_read_data: assert property (@(posedge wb_clock_i) disable iff (!rst_n_i)
        (wb_cycle_i && wb_strobe_i && !wb_we_i) |=> (wb_data_o == exp_wb_data))
        else report_mismatch("wb_data_o", $sampled(exp_wb_data), $sampled(wb_data_o));
    wb_no_stall: assert property (@(posedge wb_clock_i) disable iff (!rst_n_i)
        !wb_stall_o)
        else report_mismatch("wb_stall_o", 8'd0, DW'($sampled(wb_stall_o)));
    oe_after_read: assert property (@(posedge wb_clock_i) disable iff (!rst_n_i)
        (cpu_be_i && !cpu_we_i) |=> (cpu_data_oe_o == exp_oe))
        else report_mismatch("cpu_data_oe_o", DW'($sampled(exp_oe)),
                             DW'($sampled(cpu_data_oe_o)));
    oe_idle: assert property (@(posedge wb_clock_i) disable iff (!rst_n_i)
        !(cpu_be_i && !cpu_we_i) |=> !cpu_data_oe_o)
        else report_mismatch("cpu_data_oe_o", 8'd0, DW'($sampled(cpu_data_oe_o)));
    row_on_bus: assert property (@(posedge wb_clock_i) disable iff (!rst_n_i)
        (cpu_be_i && !cpu_we_i && exp_oe) |=> (cpu_data_o == exp_cpu_data))
        else report_mismatch("cpu_data_o", $sampled(exp_cpu_data), $sampled(cpu_data_o));
    reset_flag: assert property (@(posedge wb_clock_i) disable iff (!rst_n_i)
        cpu_reset_o == exp_reset)
        else report_mismatch("cpu_reset_o", DW'($sampled(exp_reset)),
                             DW'($sampled(cpu_reset_o)));
    gfx_flag: assert property (@(posedge wb_clock_i) disable iff (!rst_n_i)
        gfx_o == exp_gfx)
        else report_mismatch("gfx_o", DW'($sampled(exp_gfx)), DW'($sampled(gfx_o)));

    initial begin
        logic [DW-1:0] row;
        seed              = 32'hfc72;
        wb_clock_i        = 1'b0;
        rst_n_i           = 1'b0;
        wb_addr_i         = '0;
        wb_data_i         = '0;
        wb_we_i           = 1'b0;
        wb_cycle_i        = 1'b0;
        wb_strobe_i       = 1'b0;
        cpu_addr_i        = '0;
        cpu_be_i          = 1'b0;
        cpu_we_i          = 1'b0;
        cpu_data_strobe_i = 1'b0;
        cpu_data_i        = '0;
        sel_model         = '0;
        exp_reset         = 1'b0;
        exp_gfx           = 1'b0;
        exp_oe            = 1'b0;
        exp_cpu_data      = '1;
        exp_wb_data       = '0;
        for (int c = 0; c < COLS; c++) begin
            usb_model[c] = '1;                          // No keys down
            pet_model[c] = '1;
        end
        repeat (RESET_CYCLES) @(posedge wb_clock_i);
        rst_n_i <= 1'b1;

        for (int c = 0; c < COLS; c++)
            mcu_read(8'(c));                            // Reset matrix

        // Random USB rows with every fifth column left idle
        for (int c = 0; c < COLS; c++) begin
            row = DW'($random(seed));
            if (c % 5 == 0)
                row = '1;
            else
                row[c % 8] = 1'b0;                      // At least one key down
            mcu_write(8'(c), row);
        end
        for (int c = 0; c < COLS; c++) begin
            cpu_write(PIA1 + 16'd0, 8'(c));             // Port A picks the column
            row = DW'($random(seed));
            cpu_read(PIA1 + 16'd2, row);
        end
        for (int c = 0; c < COLS; c++)
            mcu_read(8'(c));                            // Snooped PET rows

        // Column 1 has a key down and only port B may intercept
        cpu_write(PIA1, 8'd1);
        cpu_read(PIA1 + 16'd0, 8'h5a);
        cpu_read(PIA1 + 16'd1, 8'h5a);
        cpu_read(PIA1 + 16'd3, 8'h5a);
        cpu_read(16'he800, 8'h5a);
        cpu_read(16'he820, 8'h5a);
        cpu_read(16'h1234, 8'h5a);
        cpu_read(PIA1 + 16'd6, 8'h3c);                  // Mirror of port B
        mcu_read(8'd1);

        mcu_write({4'h1, common_pkg::SYS_REG_RESET}, 8'h01);
        mcu_read({4'h1, common_pkg::SYS_REG_RESET});
        mcu_write({4'h1, common_pkg::SYS_REG_GFX}, 8'h01);
        mcu_read({4'h1, common_pkg::SYS_REG_GFX});
        mcu_write({4'h1, common_pkg::SYS_REG_RESET}, 8'h00);
        mcu_read({4'h1, common_pkg::SYS_REG_RESET});
        mcu_read(8'h40);                                // Unmapped
        mcu_write(8'he5, 8'h55);
        mcu_read(8'h80);

        $display("PASS: all tests");
        $finish;
    end

    // Watchdog
    initial begin
        #((NUM_OPS * OP_CYCLES + RESET_CYCLES) * 2 * CLK_HALF);
        $display("Timeout: the tests did not finish in the expected time");
        abort_run();
    end

endmodule

`default_nettype wire

/* pet_io_top.sv */
`timescale 1ns/100ps
`default_nettype none

// PET I/O snoop subsystem, MCU Wishbone on one side, 6502 bus on the other
module pet_io_top #(
    parameter int                                    KBD_COLS  = common_pkg::KBD_COL_COUNT,
    parameter logic [common_pkg::CPU_ADDR_WIDTH-1:0] PIA1_ADDR = common_pkg::PIA1_BASE
) (
    input  wire logic                                   wb_clock_i,
    input  wire logic                                   rst_n_i,
    input  wire logic [common_pkg::WB_ADDR_WIDTH-1:0]  wb_addr_i,
    input  wire logic [common_pkg::DATA_WIDTH-1:0]     wb_data_i,
    input  wire logic                                   wb_we_i,
    input  wire logic                                   wb_cycle_i,
    input  wire logic                                   wb_strobe_i,
    output logic      [common_pkg::DATA_WIDTH-1:0]     wb_data_o,
    output logic                                        wb_ack_o,
    output logic                                        wb_stall_o,
    input  wire logic [common_pkg::CPU_ADDR_WIDTH-1:0] cpu_addr_i,
    input  wire logic                                   cpu_be_i,
    input  wire logic                                   cpu_we_i,
    input  wire logic                                   cpu_data_strobe_i,
    input  wire logic [common_pkg::DATA_WIDTH-1:0]     cpu_data_i,
    output logic      [common_pkg::DATA_WIDTH-1:0]     cpu_data_o,
    output logic                                        cpu_data_oe_o,
    output logic                                        cpu_reset_o,
    output logic                                        gfx_o
);

    logic                pia1_cs;
    common_pkg::pia_rs_t pia1_rs;

    wb_bus_if kbd_bus ();   // Interconnect to keyboard
    wb_bus_if sys_bus ();   // Interconnect to system control

    address_decoding #(.PIA1_ADDR(PIA1_ADDR)) u_decode (
        .wb_clock_i (wb_clock_i),
        .cpu_addr_i (cpu_addr_i),
        .cpu_be_i   (cpu_be_i),
        .pia1_cs_o  (pia1_cs),
        .pia1_rs_o  (pia1_rs)
    );

    wb_interconnect u_interconnect (
        .wb_clock_i  (wb_clock_i),
        .rst_n_i     (rst_n_i),
        .wb_addr_i   (wb_addr_i),
        .wb_data_i   (wb_data_i),
        .wb_we_i     (wb_we_i),
        .wb_cycle_i  (wb_cycle_i),
        .wb_strobe_i (wb_strobe_i),
        .wb_data_o   (wb_data_o),
        .wb_ack_o    (wb_ack_o),
        .wb_stall_o  (wb_stall_o),
        .kbd_bus     (kbd_bus.initiator),
        .sys_bus     (sys_bus.initiator)
    );

    keyboard #(.KBD_COLS(KBD_COLS)) u_keyboard (
        .wb_clock_i        (wb_clock_i),
        .rst_n_i           (rst_n_i),
        .bus               (kbd_bus.target),
        .cpu_be_i          (cpu_be_i),
        .cpu_we_i          (cpu_we_i),
        .cpu_data_strobe_i (cpu_data_strobe_i),
        .cpu_data_i        (cpu_data_i),
        .cpu_data_o        (cpu_data_o),
        .cpu_data_oe_o     (cpu_data_oe_o),
        .pia1_cs_i         (pia1_cs),
        .pia1_rs_i         (pia1_rs)
    );

    sys_ctrl u_sys_ctrl (
        .wb_clock_i  (wb_clock_i),
        .rst_n_i     (rst_n_i),
        .bus         (sys_bus.target),
        .cpu_reset_o (cpu_reset_o),
        .gfx_o       (gfx_o)
    );

endmodule

`default_nettype wire

/* sys_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

// System control registers, CPU reset request and graphics flag
module sys_ctrl (
    input  wire logic wb_clock_i,
    input  wire logic rst_n_i,
    wb_bus_if.target  bus,
    output logic      cpu_reset_o,   // Holds the 6502 in reset while high
    output logic      gfx_o          // Graphics character set select
);

    localparam int PAD_W = common_pkg::DATA_WIDTH - 1;

    logic       request;
    logic [3:0] offset;   // Register offset within the page

    assign request   = bus.cyc && bus.stb;
    assign offset    = bus.adr[3:0];
    assign bus.stall = 1'b0;

    always_ff @(posedge wb_clock_i) begin
        if (!rst_n_i) begin
            bus.ack     <= 1'b0;
            cpu_reset_o <= 1'b0;
            gfx_o       <= 1'b0;
        end else begin
            bus.ack <= request;
            if (request && bus.we) begin
                case (offset)
                    common_pkg::SYS_REG_RESET: cpu_reset_o <= bus.dat_w[0];
                    common_pkg::SYS_REG_GFX:   gfx_o       <= bus.dat_w[0];
                    default: ;   // Other offsets ignore writes
                endcase
            end
        end
    end

    // Readback, unused offsets return zero
    always_ff @(posedge wb_clock_i) begin
        if (request) begin
            case (offset)
                common_pkg::SYS_REG_RESET: bus.dat_r <= {{PAD_W{1'b0}}, cpu_reset_o};
                common_pkg::SYS_REG_GFX:   bus.dat_r <= {{PAD_W{1'b0}}, gfx_o};
                default:                   bus.dat_r <= '0;
            endcase
        end
    end

    sys_ack_timing: assert property (
        @(posedge wb_clock_i) disable iff (!rst_n_i)
        request |=> bus.ack
    ) else $error("sys_ctrl ack missing one cycle after strobe");

endmodule

`default_nettype wire

/* keyboard.sv */
`timescale 1ns/100ps
`default_nettype none

// USB and PET keyboard matrices, with PIA1 port B read intercept
module keyboard #(
    parameter int KBD_COLS = common_pkg::KBD_COL_COUNT
) (
    input  wire logic                                   wb_clock_i,
    input  wire logic                                   rst_n_i,
    wb_bus_if.target                                    bus,
    input  wire logic                                   cpu_be_i,
    input  wire logic                                   cpu_we_i,
    input  wire logic                                   cpu_data_strobe_i,  // cpu_data_i valid
    input  wire logic [common_pkg::DATA_WIDTH-1:0]     cpu_data_i,
    output logic      [common_pkg::DATA_WIDTH-1:0]     cpu_data_o,
    output logic                                        cpu_data_oe_o,      // Intercepting read
    input  wire logic                                   pia1_cs_i,
    input  wire common_pkg::pia_rs_t                    pia1_rs_i
);

    localparam int COL_W = common_pkg::KBD_COL_WIDTH;
    localparam int ROW_W = common_pkg::KBD_ROW_COUNT;

    // All ones means no key down
    logic [KBD_COLS-1:0][ROW_W-1:0] usb_kbd;   // Written by MCU
    logic [KBD_COLS-1:0][ROW_W-1:0] pet_kbd;   // Snooped from real CPU reads

    logic [COL_W-1:0] wb_col;
    logic             wb_col_ok;
    logic             wb_request;
    logic [COL_W-1:0] selected_col;        // Last column written to port A
    logic             sel_col_ok;
    logic [ROW_W-1:0] selected_row_data;   // USB row for selected column, one clock behind
    logic             pia_strobe;
    logic             port_b_read;         // CPU read cycle on PIA1 port B

    assign wb_col     = bus.adr[COL_W-1:0];
    assign wb_col_ok  = (wb_col < KBD_COLS);
    assign wb_request = bus.cyc && bus.stb;
    assign sel_col_ok = (selected_col < KBD_COLS);

    assign bus.stall = 1'b0;   // Always single cycle

    // MCU side
    always_ff @(posedge wb_clock_i) begin
        if (!rst_n_i) begin
            bus.ack <= 1'b0;
            usb_kbd <= '1;
        end else begin
            bus.ack <= wb_request;
            if (wb_request && bus.we && wb_col_ok) begin
                usb_kbd[wb_col] <= bus.dat_w;
            end
        end
    end

    // Reads and writes both return the snooped PET column
    always_ff @(posedge wb_clock_i) begin
        if (wb_request) begin
            bus.dat_r <= wb_col_ok ? pet_kbd[wb_col] : '1;
        end
    end

    assign pia_strobe  = pia1_cs_i && cpu_data_strobe_i;
    assign port_b_read = cpu_be_i && !cpu_we_i && pia1_cs_i
                         && (pia1_rs_i == common_pkg::PIA_PORTB);

    // CPU side snoop
    always_ff @(posedge wb_clock_i) begin
        if (!rst_n_i) begin
            selected_col      <= '0;
            selected_row_data <= '1;
            pet_kbd           <= '1;
        end else begin
            // Columns past the matrix read as no keys, as on the real decoder
            selected_row_data <= sel_col_ok ? usb_kbd[selected_col] : '1;

            if (pia_strobe && cpu_we_i && pia1_rs_i == common_pkg::PIA_PORTA) begin
                selected_col <= cpu_data_i[common_pkg::PIA1_PORTA_KEY_D_OUT:
                                           common_pkg::PIA1_PORTA_KEY_A_OUT];
            end

            // Real matrix value as seen by the 6502
            if (pia_strobe && !cpu_we_i && pia1_rs_i == common_pkg::PIA_PORTB
                    && sel_col_ok) begin
                pet_kbd[selected_col] <= cpu_data_i;
            end
        end
    end

    // Intercept, drive only while a USB key is down in this column
    always_ff @(posedge wb_clock_i) begin
        if (!rst_n_i) begin
            cpu_data_oe_o <= 1'b0;
        end else begin
            cpu_data_oe_o <= port_b_read && (selected_row_data != '1);
        end
    end

    always_ff @(posedge wb_clock_i) begin
        if (port_b_read) begin
            cpu_data_o <= selected_row_data;   // Row registered in the read cycle
        end
    end

    kbd_ack_timing: assert property (
        @(posedge wb_clock_i) disable iff (!rst_n_i)
        wb_request |=> bus.ack
    ) else $error("keyboard ack missing one cycle after strobe");

    // Bus contention guard, oe only right after a port B read
    oe_needs_port_b: assert property (
        @(posedge wb_clock_i) disable iff (!rst_n_i)
        cpu_data_oe_o |-> $past(port_b_read)
    ) else $error("cpu_data_oe_o without a PIA1 port B read");

endmodule

`default_nettype wire

/* wb_interconnect.sv */
`timescale 1ns/100ps
`default_nettype none

// Single master Wishbone fabric, address bit 4 picks keyboard or system control
module wb_interconnect (
    input  wire logic                                   wb_clock_i,
    input  wire logic                                   rst_n_i,
    input  wire logic [common_pkg::WB_ADDR_WIDTH-1:0]  wb_addr_i,
    input  wire logic [common_pkg::DATA_WIDTH-1:0]     wb_data_i,
    input  wire logic                                   wb_we_i,
    input  wire logic                                   wb_cycle_i,
    input  wire logic                                   wb_strobe_i,
    output logic      [common_pkg::DATA_WIDTH-1:0]     wb_data_o,
    output logic                                        wb_ack_o,
    output logic                                        wb_stall_o,
    wb_bus_if.initiator                                 kbd_bus,
    wb_bus_if.initiator                                 sys_bus
);

    localparam int PAGE_BIT = 4;   // Bits above this must be zero

    logic request;        // Valid MCU strobe this cycle
    logic mapped;         // Address lands in one of the two pages
    logic page;
    logic unmapped_ack;   // Local answer for holes in the map

    assign request = wb_cycle_i && wb_strobe_i;
    assign mapped  = (wb_addr_i[common_pkg::WB_ADDR_WIDTH-1:PAGE_BIT+1] == '0);
    assign page    = wb_addr_i[PAGE_BIT];

    // Shared request lines fan out to both targets
    assign kbd_bus.adr   = wb_addr_i;
    assign kbd_bus.dat_w = wb_data_i;
    assign kbd_bus.we    = wb_we_i;
    assign kbd_bus.cyc   = wb_cycle_i;
    assign sys_bus.adr   = wb_addr_i;
    assign sys_bus.dat_w = wb_data_i;
    assign sys_bus.we    = wb_we_i;
    assign sys_bus.cyc   = wb_cycle_i;

    // Strobe only the addressed target
    assign kbd_bus.stb = wb_strobe_i && mapped && (page == common_pkg::WB_KBD_PAGE);
    assign sys_bus.stb = wb_strobe_i && mapped && (page == common_pkg::WB_SYS_PAGE);

    // Unmapped access still completes in one clock so the MCU never hangs
    always_ff @(posedge wb_clock_i) begin
        if (!rst_n_i) begin
            unmapped_ack <= 1'b0;
        end else begin
            unmapped_ack <= request && !mapped;
        end
    end

    // Each target's data only counts while it acks, unmapped reads give zero
    assign wb_data_o = ({common_pkg::DATA_WIDTH{kbd_bus.ack}} & kbd_bus.dat_r)
                     | ({common_pkg::DATA_WIDTH{sys_bus.ack}} & sys_bus.dat_r);
    assign wb_ack_o   = kbd_bus.ack || sys_bus.ack || unmapped_ack;
    assign wb_stall_o = kbd_bus.stall || sys_bus.stall;

    ack_after_strobe: assert property (
        @(posedge wb_clock_i) disable iff (!rst_n_i)
        wb_ack_o |-> $past(request)
    ) else $error("wb_ack_o without a strobe one cycle earlier");

    // Targets and the local responder must never answer together
    single_responder: assert property (
        @(posedge wb_clock_i) disable iff (!rst_n_i)
        $onehot0({kbd_bus.ack, sys_bus.ack, unmapped_ack})
    ) else $error("more than one Wishbone responder acked");

endmodule

`default_nettype wire

/* address_decoding.sv */
`timescale 1ns/100ps
`default_nettype none

// CPU address decode for the PIA1 window
module address_decoding #(
    parameter logic [common_pkg::CPU_ADDR_WIDTH-1:0] PIA1_ADDR = common_pkg::PIA1_BASE
) (
    input  wire logic                                    wb_clock_i,  // Only used by the check
    input  wire logic [common_pkg::CPU_ADDR_WIDTH-1:0]  cpu_addr_i,
    input  wire logic                                    cpu_be_i,    // CPU bus cycle valid
    output logic                                         pia1_cs_o,
    output common_pkg::pia_rs_t                          pia1_rs_o
);

    // Window is 16 bytes, so compare everything above bit 3
    localparam int WIN_LSB = 4;

    logic window_hit;

    assign window_hit = (cpu_addr_i[common_pkg::CPU_ADDR_WIDTH-1:WIN_LSB]
                         == PIA1_ADDR[common_pkg::CPU_ADDR_WIDTH-1:WIN_LSB]);

    assign pia1_cs_o = cpu_be_i && window_hit;   // No select outside a bus cycle

    // Register select from A1:A0, the PIA mirrors across the rest of the window
    always_comb begin
        case (cpu_addr_i[common_pkg::PIA_RS_WIDTH-1:0])
            2'd0:    pia1_rs_o = common_pkg::PIA_PORTA;
            2'd1:    pia1_rs_o = common_pkg::PIA_CRA;
            2'd2:    pia1_rs_o = common_pkg::PIA_PORTB;
            default: pia1_rs_o = common_pkg::PIA_CRB;
        endcase
    end

    // A select without a bus cycle would let the keyboard snoop garbage
    cs_needs_be: assert property (
        @(posedge wb_clock_i) !cpu_be_i |-> !pia1_cs_o
    ) else $error("pia1_cs_o high while cpu_be_i low");

endmodule

`default_nettype wire

/* wb_bus_if.sv */
`timescale 1ns/100ps
`default_nettype none

// Wishbone B4 link between the interconnect and one peripheral
interface wb_bus_if;

    logic [common_pkg::WB_ADDR_WIDTH-1:0] adr;     // Byte address
    logic [common_pkg::DATA_WIDTH-1:0]    dat_w;   // Write data, initiator to target
    logic [common_pkg::DATA_WIDTH-1:0]    dat_r;   // Read data, valid with ack
    logic                                 we;      // High for write
    logic                                 cyc;     // Cycle in progress
    logic                                 stb;     // Strobe, doubles as target select
    logic                                 ack;     // One clock after stb
    logic                                 stall;   // Tied low by every target

    // Interconnect side
    modport initiator (
        output adr, dat_w, we, cyc, stb,
        input  dat_r, ack, stall
    );

    // Peripheral side
    modport target (
        input  adr, dat_w, we, cyc, stb,
        output dat_r, ack, stall
    );

endinterface

`default_nettype wire

/* common_pkg.sv */
`default_nettype none

package common_pkg;

    // Bus widths
    localparam int DATA_WIDTH     = 8;    // CPU and Wishbone data
    localparam int WB_ADDR_WIDTH  = 8;    // Wishbone byte address
    localparam int CPU_ADDR_WIDTH = 16;   // 6502 address bus

    // Keyboard matrix dimensions
    localparam int KBD_COL_COUNT = 10;
    localparam int KBD_COL_WIDTH = 4;     // Enough bits to select one of 10 columns
    localparam int KBD_ROW_COUNT = 8;     // One bit per row, low when pressed

    // PIA register select, taken straight from CPU address bits 1:0
    localparam int PIA_RS_WIDTH = 2;

    typedef enum logic [PIA_RS_WIDTH-1:0] {
        PIA_PORTA = 2'd0,   // Port A data / DDR
        PIA_CRA   = 2'd1,   // Control register A
        PIA_PORTB = 2'd2,   // Port B data / DDR
        PIA_CRB   = 2'd3    // Control register B
    } pia_rs_t;

    // PIA1 occupies the 16 byte window E810..E81F
    localparam logic [CPU_ADDR_WIDTH-1:0] PIA1_BASE = 16'hE810;

    // Port A bits that drive the keyboard column decoder
    localparam int PIA1_PORTA_KEY_A_OUT = 0;
    localparam int PIA1_PORTA_KEY_D_OUT = 3;

    // Wishbone address bit 4 picks the target
    localparam logic WB_KBD_PAGE = 1'b0;
    localparam logic WB_SYS_PAGE = 1'b1;

    // System control register offsets, address bits 3:0
    localparam logic [3:0] SYS_REG_RESET = 4'd0;   // CPU reset request
    localparam logic [3:0] SYS_REG_GFX   = 4'd1;   // Graphics character set

endpackage

`default_nettype wire
